/* hdl/smc_lite_pkg.sv */
// SMC lite shared types

package smc_lite_pkg;

  //--------------------------------------------------------------------------
  // AHB bus encodings
  //--------------------------------------------------------------------------

  // Transfer type on htrans
  typedef enum logic [1:0]
  {
    trn_idle   = 2'b00,  // No transfer
    trn_busy   = 2'b01,  // Master inserting a pause
    trn_nonseq = 2'b10,  // First or single beat
    trn_seq    = 2'b11   // Later burst beat
  } htrans_t;

  // Transfer size on hsize, wider sizes not supported
  typedef enum logic [2:0]
  {
    sz_byte = 3'b000,
    sz_half = 3'b001,
    sz_word = 3'b010
  } hsize_t;

  // Slave response on hresp
  typedef enum logic [1:0]
  {
    rsp_okay  = 2'b00,
    rsp_error = 2'b01,
    rsp_retry = 2'b10,  // Never issued here
    rsp_split = 2'b11   // Never issued here
  } hresp_t;

  //--------------------------------------------------------------------------
  // Controller internal types
  //--------------------------------------------------------------------------

  // Size stored for the access control block
  typedef enum logic [1:0]
  {
    xfer_byte = 2'b00,
    xfer_half = 2'b01,
    xfer_word = 2'b10
  } xfer_size_t;

  typedef logic [31:0] word_t;  // Data or address word

endpackage

/* hdl/smc_ahb_lite_if.sv */
// AHB-Lite slave interface

`timescale 1ns/1ns

module smc_ahb_lite_if
  import smc_lite_pkg::*;
(
  input  logic       hclk25,         // AHB clock
  input  logic       n_sys_reset25,  // Async reset, active low
  input  logic       hsel,           // Slave select for the one bank
  input  word_t      haddr,
  input  htrans_t    htrans,
  input  logic       hwrite,
  input  hsize_t     hsize,
  input  word_t      hwdata,
  input  logic       hready,         // Muxed system ready
  input  logic       smc_idle,       // Timing FSM has no beat running
  input  logic       smc_done,       // Last cycle of a beat
  input  logic       mac_done,       // Last beat of the transfer
  input  word_t      read_data,      // Assembled read word
  output word_t      smc_hrdata,
  output logic       smc_hready,
  output hresp_t     smc_hresp,
  output logic       smc_valid,      // Ack back to the decoder
  output logic       new_access,     // Start strobe for MAC and FSM
  output xfer_size_t xfer_size,
  output word_t      addr,
  output word_t      write_data,
  output logic       n_read          // Low for a read
);

  logic active_xfer;  // NONSEQ or SEQ on the bus
  logic misaligned;
  logic mis_err;      // Misaligned access seen in address phase
  logic engine_free;  // FSM can take a new access now
  logic r_ready;      // Registered part of hready
  logic r_hresp;      // Second error cycle pending

  //--------------------------------------------------------------------------
  // Address phase decode
  //--------------------------------------------------------------------------

  assign active_xfer = (htrans == trn_nonseq) || (htrans == trn_seq);

  // Half on odd byte or word off a 4-byte boundary
  assign misaligned = ((hsize == sz_half) && haddr[0]) ||
                      ((hsize == sz_word) && (haddr[1:0] != 2'b00));

  assign mis_err = misaligned && active_xfer && hsel && hready;

  // Idle FSM, or final cycle of the running transfer
  assign engine_free = smc_idle || (smc_done && mac_done);

  assign new_access = active_xfer && hsel && hready && !mis_err && engine_free;
  assign smc_valid  = new_access;

  // Straight pass to the blocks behind
  assign xfer_size  = xfer_size_t'(hsize[1:0]);
  assign addr       = haddr;
  assign n_read     = hwrite;     // Write means read not active
  assign write_data = hwdata;     // Valid in the data phase only
  assign smc_hrdata = read_data;

  //--------------------------------------------------------------------------
  // Response, two cycles of ERROR on misalignment
  //--------------------------------------------------------------------------

  always_ff @(posedge hclk25 or negedge n_sys_reset25)
  begin
    if (!n_sys_reset25)
    begin
      smc_hresp <= rsp_okay;
      r_hresp   <= 1'b0;
    end
    else if (mis_err)
    begin
      smc_hresp <= rsp_error;  // First cycle with ready low
      r_hresp   <= 1'b1;
    end
    else if (r_hresp)
    begin
      smc_hresp <= rsp_error;  // Second cycle with ready high
      r_hresp   <= 1'b0;
    end
    else
    begin
      smc_hresp <= rsp_okay;
      r_hresp   <= 1'b0;
    end
  end

  //--------------------------------------------------------------------------
  // Ready generation
  //--------------------------------------------------------------------------

  // Sampled only when the bus moves on; held through stalls
  always_ff @(posedge hclk25 or negedge n_sys_reset25)
  begin
    if (!n_sys_reset25)
      r_ready <= 1'b1;
    else if (r_hresp)
      r_ready <= 1'b1;                           // Ends the error pair
    else if (hready)
      r_ready <= !(new_access || mis_err);       // Idle, busy, not selected
  end

  // Data phase ends when the last beat completes
  assign smc_hready = r_ready || (smc_done && mac_done);

endmodule

/* hdl/smc_mac_lite.sv */
// Multiple access control

`timescale 1ns/1ns

module smc_mac_lite
  import smc_lite_pkg::*;
#(
  parameter int ext_width = 8  // External data width, 8, 16 or 32
)
(
  input  logic                   hclk25,
  input  logic                   n_sys_reset25,
  input  logic                   new_access,  // Access accepted this cycle
  input  xfer_size_t             xfer_size,
  input  word_t                  addr,
  input  word_t                  write_data,  // AHB write data, data phase
  input  logic                   beat_start,  // First cycle of a beat
  input  logic                   smc_done,    // Last cycle of a beat
  input  logic [ext_width-1:0]   mem_rdata,
  output logic                   mac_done,    // Running the last beat
  output word_t                  read_data,
  output word_t                  mem_addr,
  output logic [ext_width-1:0]   mem_wdata,
  output logic [ext_width/8-1:0] n_mem_be
);

  localparam int beat_bytes = ext_width / 8;
  localparam int beat_shift = $clog2(beat_bytes);

  logic [2:0] n_beats;      // Beats for the incoming transfer
  logic [3:0] lane_mask;    // AHB lanes the incoming transfer covers
  logic [2:0] beats_left;   // Including the one in progress
  logic [1:0] beat_idx;
  logic [3:0] lane_mask_q;
  word_t      base_q;       // Base address aligned to the beat
  word_t      wdata_q;
  word_t      rdata_q;      // Read bytes of finished beats
  word_t      wdata_cur;
  word_t      rdata_mrg;
  logic [1:0] beat_lane;    // AHB lane of external byte 0
  logic       first_beat;
  logic       active;

  //--------------------------------------------------------------------------
  // Decode of the new transfer
  //--------------------------------------------------------------------------

  always_comb
  begin
    case (xfer_size)
      xfer_half: n_beats = (beat_bytes == 1) ? 3'd2 : 3'd1;
      xfer_word: n_beats = 3'(4 / beat_bytes);
      default:   n_beats = 3'd1;  // Byte always fits one beat
    endcase
  end

  always_comb
  begin
    case (xfer_size)
      xfer_half: lane_mask = 4'b0011 << addr[1:0];
      xfer_word: lane_mask = 4'b1111;
      default:   lane_mask = 4'b0001 << addr[1:0];
    endcase
  end

  //--------------------------------------------------------------------------
  // Beat counting
  //--------------------------------------------------------------------------

  always_ff @(posedge hclk25 or negedge n_sys_reset25)
  begin
    if (!n_sys_reset25)
    begin
      beats_left  <= 3'd0;
      beat_idx    <= 2'd0;
      lane_mask_q <= 4'd0;
    end
    else if (new_access)             // Wins over the ending beat
    begin
      beats_left  <= n_beats;
      beat_idx    <= 2'd0;
      lane_mask_q <= lane_mask;
    end
    else if (smc_done && active)
    begin
      beats_left <= beats_left - 3'd1;
      beat_idx   <= beat_idx + 2'd1;
    end
  end

  assign active     = (beats_left != 3'd0);
  assign mac_done   = (beats_left == 3'd1);
  assign first_beat = beat_start && (beat_idx == 2'd0);  // Data phase T+1

  // Data registers
  always_ff @(posedge hclk25)
  begin
    if (new_access)
      base_q <= addr & ~word_t'(beat_bytes - 1);
    if (first_beat)
      wdata_q <= write_data;
    if (smc_done)
      rdata_q[{beat_lane, 3'b000} +: ext_width] <= mem_rdata;
  end

  //--------------------------------------------------------------------------
  // External side, address, write lane and byte enables
  //--------------------------------------------------------------------------

  assign mem_addr  = base_q + (word_t'(beat_idx) << beat_shift);
  assign beat_lane = mem_addr[1:0];  // Zero for a 32-bit bus

  // Live hwdata until the capture lands
  assign wdata_cur = first_beat ? write_data : wdata_q;
  assign mem_wdata = wdata_cur[{beat_lane, 3'b000} +: ext_width];

  always_comb
  begin
    for (int j = 0; j < beat_bytes; j++)
      n_mem_be[j] = !(active && lane_mask_q[beat_lane + j]);  // Low on covered bytes
  end

  // Last beat merged live, uncovered lanes forced to zero
  always_comb
  begin
    rdata_mrg = rdata_q;
    if (mac_done)
      rdata_mrg[{beat_lane, 3'b000} +: ext_width] = mem_rdata;
    for (int b = 0; b < 4; b++)
      read_data[b*8 +: 8] = lane_mask_q[b] ? rdata_mrg[b*8 +: 8] : 8'h00;
  end

endmodule

/* hdl/smc_state_lite.sv */
// External access timing FSM

`timescale 1ns/1ns

module smc_state_lite
#(
  parameter int ext_width   = 8,  // External data width
  parameter int wait_states = 1   // Extra cycles per beat, 0 to 7
)
(
  input  logic hclk25,
  input  logic n_sys_reset25,
  input  logic new_access,  // Access accepted this cycle
  input  logic n_read,      // Direction of the accepted access
  input  logic mac_done,    // Current beat is the last one
  output logic smc_idle,
  output logic smc_done,    // Last cycle of a beat
  output logic beat_start,  // First cycle of a beat
  output logic n_mem_cs,
  output logic n_mem_oe,
  output logic n_mem_we
);

  // Done state is the closing cycle of every beat
  typedef enum logic [1:0]
  {
    st_idle   = 2'b00,
    st_access = 2'b01,  // Wait cycles of a beat
    st_done   = 2'b10   // Turnaround into next beat or idle
  } state_t;

  state_t     state;
  state_t     state_nxt;
  logic [2:0] wait_cnt;      // Wait cycles left in the beat
  logic [2:0] wait_cnt_nxt;
  logic       beat_nxt;      // A beat starts next cycle
  logic       wr_q;          // Latched direction, high for write

  // Elaboration check on the parameter range
  if (!((ext_width == 8) || (ext_width == 16) || (ext_width == 32)) ||
      (wait_states < 0) || (wait_states > 7))
  begin : g_param_check
    $error("smc_state_lite: ext_width or wait_states out of range");
  end

  //--------------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------------

  always_comb
  begin
    state_nxt    = state;
    wait_cnt_nxt = wait_cnt;
    beat_nxt     = 1'b0;
    case (state)
      st_idle:
        if (new_access)
          beat_nxt = 1'b1;
      st_access:
        if (wait_cnt == 3'd1)
          state_nxt = st_done;
        else
          wait_cnt_nxt = wait_cnt - 3'd1;
      st_done:
        if (!mac_done || new_access)  // More beats, or back-to-back
          beat_nxt = 1'b1;
        else
          state_nxt = st_idle;
      default:
        state_nxt = st_idle;
    endcase

    // Every beat opens the same way
    if (beat_nxt)
    begin
      state_nxt    = (wait_states == 0) ? st_done : st_access;
      wait_cnt_nxt = 3'(wait_states);
    end
  end

  //--------------------------------------------------------------------------
  // State registers
  //--------------------------------------------------------------------------

  always_ff @(posedge hclk25 or negedge n_sys_reset25)
  begin
    if (!n_sys_reset25)
    begin
      state      <= st_idle;
      wait_cnt   <= 3'd0;
      beat_start <= 1'b0;
      wr_q       <= 1'b0;
    end
    else
    begin
      state      <= state_nxt;
      wait_cnt   <= wait_cnt_nxt;
      beat_start <= beat_nxt;
      if (new_access)
        wr_q <= n_read;  // n_read high means write
    end
  end

  //--------------------------------------------------------------------------
  // Strobes, low for the whole beat
  //--------------------------------------------------------------------------

  assign smc_idle = (state == st_idle);
  assign smc_done = (state == st_done);
  assign n_mem_cs = smc_idle;
  assign n_mem_oe = smc_idle || wr_q;   // Reads only
  assign n_mem_we = smc_idle || !wr_q;  // SRAM writes while low

endmodule

/* hdl/smc_lite_top.sv */
// Static memory controller top level

`timescale 1ns/1ns

module smc_lite_top
  import smc_lite_pkg::*;
#(
  parameter int ext_width   = 8,  // SRAM data width
  parameter int wait_states = 1   // Extra cycles per beat
)
(
  input  logic                   hclk25,
  input  logic                   n_sys_reset25,
  // AHB-Lite slave port
  input  logic                   hsel,
  input  word_t                  haddr,
  input  htrans_t                htrans,
  input  logic                   hwrite,
  input  hsize_t                 hsize,
  input  word_t                  hwdata,
  input  logic                   hready,
  output word_t                  smc_hrdata,
  output logic                   smc_hready,
  output hresp_t                 smc_hresp,
  // Asynchronous SRAM
  output word_t                  mem_addr,
  output logic [ext_width-1:0]   mem_wdata,
  input  logic [ext_width-1:0]   mem_rdata,
  output logic                   n_mem_cs,
  output logic                   n_mem_oe,
  output logic                   n_mem_we,
  output logic [ext_width/8-1:0] n_mem_be
);

  logic       new_access;
  xfer_size_t xfer_size;
  word_t      addr;
  word_t      write_data;
  logic       n_read;
  word_t      read_data;   // From MAC lanes
  logic       mac_done;
  logic       smc_done;
  logic       smc_idle;
  logic       beat_start;

  //--------------------------------------------------------------------------
  // Bus interface, access control, timing FSM
  //--------------------------------------------------------------------------

  smc_ahb_lite_if i_ahb_if
  (
    .hclk25        (hclk25),
    .n_sys_reset25 (n_sys_reset25),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hsize         (hsize),
    .hwdata        (hwdata),
    .hready        (hready),
    .smc_idle      (smc_idle),
    .smc_done      (smc_done),
    .mac_done      (mac_done),
    .read_data     (read_data),
    .smc_hrdata    (smc_hrdata),
    .smc_hready    (smc_hready),
    .smc_hresp     (smc_hresp),
    .smc_valid     (),            // Single slave, no decoder ack
    .new_access    (new_access),
    .xfer_size     (xfer_size),
    .addr          (addr),
    .write_data    (write_data),
    .n_read        (n_read)
  );

  smc_mac_lite #(.ext_width(ext_width)) i_mac
  (
    .hclk25        (hclk25),
    .n_sys_reset25 (n_sys_reset25),
    .new_access    (new_access),
    .xfer_size     (xfer_size),
    .addr          (addr),
    .write_data    (write_data),
    .beat_start    (beat_start),
    .smc_done      (smc_done),
    .mem_rdata     (mem_rdata),
    .mac_done      (mac_done),
    .read_data     (read_data),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .n_mem_be      (n_mem_be)
  );

  smc_state_lite #(.ext_width(ext_width), .wait_states(wait_states)) i_state
  (
    .hclk25        (hclk25),
    .n_sys_reset25 (n_sys_reset25),
    .new_access    (new_access),
    .n_read        (n_read),
    .mac_done      (mac_done),
    .smc_idle      (smc_idle),
    .smc_done      (smc_done),
    .beat_start    (beat_start),
    .n_mem_cs      (n_mem_cs),
    .n_mem_oe      (n_mem_oe),
    .n_mem_we      (n_mem_we)
  );

endmodule

/* sim/smc_sram_model.sv */
// Asynchronous SRAM model

`timescale 1ns/1ns

module smc_sram_model
#(
  parameter int ext_width   = 8,     // Data width, 8, 16 or 32
  parameter int depth_bytes = 1024   // Size in bytes, wraps above
)
(
  input  logic [31:0]            mem_addr,   // Byte address
  input  logic [ext_width-1:0]   mem_wdata,
  output logic [ext_width-1:0]   mem_rdata,
  input  logic                   n_mem_cs,
  input  logic                   n_mem_oe,
  input  logic                   n_mem_we,
  input  logic [ext_width/8-1:0] n_mem_be    // Low for bytes to write
);

  localparam int bytes_per = ext_width / 8;
  localparam int entries   = depth_bytes / bytes_per;

  logic [ext_width-1:0] mem [entries];
  logic [31:0]          idx;                 // Entry under the address

  assign idx = (mem_addr / bytes_per) % entries;

  // Read path, bus parked low when not driven
  assign mem_rdata = (!n_mem_cs && !n_mem_oe) ? mem[idx] : '0;

  // Level-sensitive write, taken once address and data have settled
  always
  begin
    @(mem_addr or mem_wdata or n_mem_cs or n_mem_we or n_mem_be);
    #1;
    if (!n_mem_cs && !n_mem_we)
      for (int b = 0; b < bytes_per; b++)
        if (!n_mem_be[b])
          mem[idx][b*8 +: 8] = mem_wdata[b*8 +: 8];
  end

  // Backdoor load of one byte
  task automatic load_byte(input int unsigned a, input logic [7:0] v);
    mem[(a / bytes_per) % entries][(a % bytes_per)*8 +: 8] = v;
  endtask

endmodule

/* sim/smc_lite_sva.sv */
// Strobe checks for the timing FSM

`timescale 1ns/1ns

module smc_lite_sva
#(
  parameter int wait_states = 1
)
(
  input logic hclk25,
  input logic n_sys_reset25,
  input logic smc_done,
  input logic n_mem_cs,
  input logic n_mem_oe,
  input logic n_mem_we
);

  localparam int cs_min = wait_states + 1;  // Cycles in one beat

  // Read and write strobes never overlap
  a_oe_we_excl: assert property (@(posedge hclk25) disable iff (!n_sys_reset25)
    !(!n_mem_oe && !n_mem_we))
    else $error("n_mem_oe and n_mem_we low in the same cycle");

  a_strobe_cs: assert property (@(posedge hclk25) disable iff (!n_sys_reset25)
    (!n_mem_oe || !n_mem_we) |-> !n_mem_cs)
    else $error("strobe active while n_mem_cs is high");

  a_done_cs: assert property (@(posedge hclk25) disable iff (!n_sys_reset25)
    smc_done |-> !n_mem_cs)
    else $error("smc_done outside a chip select window");

  // At least one full beat per chip select
  a_cs_min_len: assert property (@(posedge hclk25) disable iff (!n_sys_reset25)
    $fell(n_mem_cs) |-> (!n_mem_cs) [*cs_min])
    else $error("n_mem_cs low for fewer than wait_states+1 cycles");

endmodule

/* sim/smc_lite_tb.sv */
// SMC lite testbench

`timescale 1ns/1ns

module smc_lite_tb
  import smc_lite_pkg::*;
();

  localparam int ext_width   = 8;
  localparam int wait_states = 1;
  localparam int beat_bytes  = ext_width / 8;
  localparam int depth_bytes = 1024;
  localparam int num_rows    = 26;
  localparam int clk_period  = 4;
  localparam int timeout_ns  = (num_rows * 20 + 16 + 8) * clk_period;  // 20 cycles per row

  // One AHB transfer of the stimulus table
  typedef struct packed
  {
    logic    hsel;
    htrans_t htrans;
    logic    hwrite;
    hsize_t  hsize;
    word_t   haddr;
    word_t   data;      // Write data or zero for a read
    hresp_t  resp;      // Expected response
  } row_t;

  logic                  hclk25 = 1'b0;
  logic                  n_sys_reset25;
  logic                  hsel;
  word_t                 haddr;
  htrans_t               htrans;
  logic                  hwrite;
  hsize_t                hsize;
  word_t                 hwdata;
  logic                  hready;
  word_t                 smc_hrdata;
  logic                  smc_hready;
  hresp_t                smc_hresp;
  word_t                 mem_addr;
  logic [ext_width-1:0]  mem_wdata;
  logic [ext_width-1:0]  mem_rdata;
  logic                  n_mem_cs;
  logic                  n_mem_oe;
  logic                  n_mem_we;
  logic [beat_bytes-1:0] n_mem_be;

  row_t        rows [num_rows];
  logic [7:0]  ref_mem [depth_bytes];  // Expected SRAM contents
  int          n_built;
  int          value_errors;
  int          other_errors;
  int unsigned seed_val;

  always #(clk_period / 2) hclk25 = ~hclk25;

  assign hready = smc_hready;  // Only slave on the bus

  smc_lite_top #(.ext_width(ext_width), .wait_states(wait_states)) i_dut
  (
    .hclk25(hclk25), .n_sys_reset25(n_sys_reset25),
    .hsel(hsel), .haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hsize(hsize),
    .hwdata(hwdata), .hready(hready),
    .smc_hrdata(smc_hrdata), .smc_hready(smc_hready), .smc_hresp(smc_hresp),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
    .n_mem_cs(n_mem_cs), .n_mem_oe(n_mem_oe), .n_mem_we(n_mem_we), .n_mem_be(n_mem_be)
  );

  smc_sram_model #(.ext_width(ext_width), .depth_bytes(depth_bytes)) i_sram
  (
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
    .n_mem_cs(n_mem_cs), .n_mem_oe(n_mem_oe), .n_mem_we(n_mem_we), .n_mem_be(n_mem_be)
  );

  bind smc_state_lite smc_lite_sva #(.wait_states(wait_states)) i_sva
  (
    .hclk25(hclk25), .n_sys_reset25(n_sys_reset25), .smc_done(smc_done),
    .n_mem_cs(n_mem_cs), .n_mem_oe(n_mem_oe), .n_mem_we(n_mem_we)
  );

  //--------------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------------

  task automatic check_word(input word_t act, input word_t exp, input string name);
    if (act !== exp)
    begin
      $display("FAILED t=%0t %s: got %h, expected %h", $time, name, act, exp);
      value_errors++;
    end
  endtask

  task automatic check_resp(input hresp_t act, input hresp_t exp, input string name);
    if (act !== exp)
    begin
      $display("FAILED t=%0t %s: got %b, expected %b", $time, name, act, exp);
      value_errors++;
    end
  endtask

  task automatic check_count(input int act, input int exp, input string name);
    if (act != exp)
    begin
      $display("FAILED t=%0t %s: got %0d, expected %0d", $time, name, act, exp);
      value_errors++;
    end
  endtask

  //--------------------------------------------------------------------------
  // Transfer rules
  //--------------------------------------------------------------------------

  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'(a ^ (a >> 5) ^ 32'h96);  // Mixes all ten address bits
  endfunction

  function automatic logic is_access(input row_t r);
    return r.hsel && ((r.htrans == trn_nonseq) || (r.htrans == trn_seq));
  endfunction

  function automatic logic is_misaligned(input row_t r);
    return ((r.hsize == sz_half) && r.haddr[0]) ||
           ((r.hsize == sz_word) && (r.haddr[1:0] != 2'b00));
  endfunction

  // Cycles from first data-phase cycle to hready high
  function automatic int expected_len(input row_t r);
    int nbytes;
    int beats;
    nbytes = 1 << r.hsize;
    beats  = (nbytes > beat_bytes) ? nbytes / beat_bytes : 1;
    if (!is_access(r))
      return 1;                          // Zero wait okay
    if (is_misaligned(r))
      return 2;                          // Error pair
    return beats * (wait_states + 1);
  endfunction

  task automatic add_row(input logic sel, input htrans_t trn, input logic wr,
                         input hsize_t sz, input word_t a, input hresp_t rsp);
    row_t r;
    r.hsel   = sel;
    r.htrans = trn;
    r.hwrite = wr;
    r.hsize  = sz;
    r.haddr  = a;
    r.data   = wr ? word_t'($urandom) : '0;
    r.resp   = rsp;
    rows[n_built] = r;
    n_built++;
  endtask

  task automatic build_table();
    add_row(1, trn_nonseq, 1, sz_word, 'h010, rsp_okay);  // Write then read back to back
    add_row(1, trn_nonseq, 0, sz_word, 'h010, rsp_okay);
    add_row(1, trn_nonseq, 1, sz_half, 'h022, rsp_okay);
    add_row(1, trn_nonseq, 1, sz_byte, 'h021, rsp_okay);
    add_row(1, trn_nonseq, 0, sz_word, 'h020, rsp_okay);  // Fill and written lanes mixed
    add_row(1, trn_nonseq, 0, sz_half, 'h022, rsp_okay);
    add_row(1, trn_nonseq, 0, sz_byte, 'h021, rsp_okay);
    add_row(1, trn_nonseq, 0, sz_half, 'h020, rsp_okay);
    add_row(1, trn_idle,   1, sz_byte, 'h011, rsp_okay);  // No-op transfers
    add_row(1, trn_busy,   1, sz_word, 'h010, rsp_okay);
    add_row(0, trn_nonseq, 1, sz_word, 'h010, rsp_okay);
    add_row(1, trn_nonseq, 0, sz_word, 'h010, rsp_okay);  // Still the first write
    add_row(1, trn_nonseq, 1, sz_half, 'h013, rsp_error); // Misaligned
    add_row(1, trn_nonseq, 1, sz_word, 'h012, rsp_error);
    add_row(1, trn_nonseq, 0, sz_word, 'h011, rsp_error);
    add_row(1, trn_nonseq, 0, sz_word, 'h010, rsp_okay);
    add_row(1, trn_seq,    1, sz_byte, 'h033, rsp_okay);
    add_row(1, trn_seq,    1, sz_byte, 'h032, rsp_okay);
    add_row(1, trn_nonseq, 1, sz_half, 'h030, rsp_okay);
    add_row(1, trn_nonseq, 0, sz_word, 'h030, rsp_okay);
    add_row(1, trn_nonseq, 0, sz_byte, 'h033, rsp_okay);
    add_row(1, trn_nonseq, 1, sz_word, 'h3fc, rsp_okay);  // Top of SRAM
    add_row(1, trn_nonseq, 0, sz_half, 'h3fe, rsp_okay);
    add_row(1, trn_nonseq, 0, sz_word, 'h3fc, rsp_okay);
    add_row(0, trn_nonseq, 0, sz_word, 'h3fc, rsp_okay);
    add_row(1, trn_nonseq, 0, sz_byte, 'h100, rsp_okay);  // Fill pattern only
  endtask

  //--------------------------------------------------------------------------
  // AHB master
  //--------------------------------------------------------------------------

  task automatic drive_addr(input int i);
    if (i < num_rows)
    begin
      hsel   <= rows[i].hsel;
      htrans <= rows[i].htrans;
      hwrite <= rows[i].hwrite;
      hsize  <= rows[i].hsize;
      haddr  <= rows[i].haddr;
    end
    else
    begin
      hsel   <= 1'b0;    // Park the bus
      htrans <= trn_idle;
    end
  endtask

  // Update or consult the reference once the data phase completes
  task automatic finish_row(input int i, input int cycles);
    row_t        r;
    word_t       exp;
    int unsigned a;
    r   = rows[i];
    exp = '0;                            // Uncovered lanes read as zero
    check_count(cycles, expected_len(r), $sformatf("row %0d data phase cycles", i));
    if (is_access(r) && !is_misaligned(r))
    begin
      for (int k = 0; k < (1 << r.hsize); k++)
      begin
        a = (r.haddr + k) % depth_bytes;
        if (r.hwrite)
          ref_mem[a] = r.data[(a % 4)*8 +: 8];
        else
          exp[(a % 4)*8 +: 8] = ref_mem[a];
      end
      if (!r.hwrite)
        check_word(smc_hrdata, exp, $sformatf("row %0d smc_hrdata", i));
    end
  endtask

  // Pipelined run sampling at negedge and driving at posedge
  task automatic run_table();
    int   a_idx;
    int   d_idx;
    int   cycles;
    logic ready;
    a_idx  = 0;
    d_idx  = -1;
    cycles = 0;
    @(posedge hclk25);
    drive_addr(0);
    while ((a_idx < num_rows) || (d_idx >= 0))
    begin
      @(negedge hclk25);
      ready = smc_hready;
      if (d_idx >= 0)
      begin
        cycles++;
        check_resp(smc_hresp, rows[d_idx].resp, $sformatf("row %0d smc_hresp", d_idx));
        if ((rows[d_idx].resp == rsp_error) && !n_mem_cs)
        begin
          $display("ERROR t=%0t row %0d: SRAM selected during a misaligned access",
                   $time, d_idx);
          other_errors++;
        end
        if (ready)
          finish_row(d_idx, cycles);
      end
      @(posedge hclk25);
      if (ready)                         // Address phase moves to data phase
      begin
        d_idx = (a_idx < num_rows) ? a_idx : -1;
        if (d_idx >= 0)
          hwdata <= rows[d_idx].data;
        if (a_idx < num_rows)
          a_idx++;
        cycles = 0;
        drive_addr(a_idx);
      end
    end
  endtask

  //--------------------------------------------------------------------------
  // Main sequence and watchdog
  //--------------------------------------------------------------------------

  initial
  begin
    seed_val      = $urandom(32'h0de5af45);
    n_sys_reset25 = 1'b0;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = trn_idle;
    hwrite        = 1'b0;
    hsize         = sz_byte;
    hwdata        = '0;
    n_built       = 0;
    value_errors  = 0;
    other_errors  = 0;
    build_table();
    for (int a = 0; a < depth_bytes; a++)
    begin
      ref_mem[a] = fill_byte(a);
      i_sram.load_byte(a, fill_byte(a));
    end
    repeat (16) @(posedge hclk25);
    n_sys_reset25 <= 1'b1;
    @(negedge hclk25);
    // Ready, strobes, byte enables and idle all high
    check_word(word_t'({smc_hready, n_mem_cs, n_mem_oe, n_mem_we, n_mem_be,
                        i_dut.i_state.smc_idle}),
               (word_t'(1) << (5 + beat_bytes)) - 1, "reset state bits");
    check_resp(smc_hresp, rsp_okay, "smc_hresp after reset");
    run_table();
    $display("Error count: %0d value, %0d other", value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0))
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  initial
  begin
    #(timeout_ns);
    $display("ERROR: timeout, the table did not complete within %0d ns", timeout_ns);
    other_errors++;
    $display("Error count: %0d value, %0d other", value_errors, other_errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* smc_lite.f */
hdl/smc_lite_pkg.sv
hdl/smc_ahb_lite_if.sv
hdl/smc_mac_lite.sv
hdl/smc_state_lite.sv
hdl/smc_lite_top.sv
sim/smc_sram_model.sv
sim/smc_lite_sva.sv
sim/smc_lite_tb.sv
